/* filelist.f */
+incdir+logic
logic/rover_pkg.sv
logic/ir_frame_decoder.sv
logic/rover_mode_fsm.sv
logic/motor_driver.sv
logic/status_display.sv
logic/rover_top.sv
tb/tb_clock.sv
tb/rover_tb.sv

/* logic/ir_frame_decoder.sv */
`timescale 1ns/1ps
`include "rover_defines.svh"

module ir_frame_decoder #(
    parameter int unit_cycles = `IR_UNIT_CYCLES
) (
    input  logic               clk_50,
    input  logic               rst_n,
    input  logic               ir_line,
    output rover_pkg::ir_cmd_t cmd,
    output logic               cmd_valid
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_LEAD_MARK,
        S_LEAD_SPACE,
        S_BIT_MARK,
        S_BIT_SPACE,
        S_STOP
    } dec_state_e;

    // the leader mark at the top of its window is the longest legal phase
    localparam int MAX_LEN = (`IR_LEAD_MARK_UNITS * unit_cycles * `IR_TOL_HIGH_NUM) / `IR_TOL_DEN;
    localparam int CNT_W = $clog2(MAX_LEN + 2) + 1;

    dec_state_e       state;
    logic             ir_meta;
    logic             ir_sync;
    logic             ir_prev;
    logic             rise;
    logic             fall;
    logic [CNT_W-1:0] len_cnt;
    logic [4:0]       bit_cnt;
    logic [31:0]      shift_reg;
    logic             space_zero;
    logic             space_one;
    logic             frame_done;

    function automatic logic in_window(input logic [CNT_W-1:0] len, input int units);
        int nominal;
        int len_x;
        nominal = units * unit_cycles;
        len_x = int'(len);
        return (len_x * `IR_TOL_DEN >= nominal * `IR_TOL_LOW_NUM) &&
               (len_x * `IR_TOL_DEN <= nominal * `IR_TOL_HIGH_NUM);
    endfunction

    // line idles high, so the synchroniser resets to one
    always_ff @(posedge clk_50) begin
        if (!rst_n) begin
            ir_meta <= 1'b1;
            ir_sync <= 1'b1;
            ir_prev <= 1'b1;
        end else begin
            ir_meta <= ir_line;
            ir_sync <= ir_meta;
            ir_prev <= ir_sync;
        end
    end

    assign rise = ir_sync & ~ir_prev;
    assign fall = ~ir_sync & ir_prev;

    // holds the length of the level that an edge just ended
    always_ff @(posedge clk_50) begin
        if (!rst_n)
            len_cnt <= '0;
        else if (rise || fall)
            len_cnt <= CNT_W'(1);
        else if (len_cnt <= CNT_W'(MAX_LEN))
            len_cnt <= len_cnt + 1'b1;
    end

    assign space_zero = in_window(len_cnt, `IR_ZERO_SPACE_UNITS);
    assign space_one  = in_window(len_cnt, `IR_ONE_SPACE_UNITS);

    always_ff @(posedge clk_50) begin
        if (!rst_n) begin
            state      <= S_IDLE;
            bit_cnt    <= '0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            if (state != S_IDLE && len_cnt > CNT_W'(MAX_LEN)) begin
                // line stuck in one level, drop the frame
                state <= S_IDLE;
            end else begin
                case (state)
                    S_IDLE: if (fall) state <= S_LEAD_MARK;
                    S_LEAD_MARK: if (rise)
                        state <= in_window(len_cnt, `IR_LEAD_MARK_UNITS) ? S_LEAD_SPACE : S_IDLE;
                    S_LEAD_SPACE: if (fall) begin
                        bit_cnt <= '0;
                        state <= in_window(len_cnt, `IR_LEAD_SPACE_UNITS) ? S_BIT_MARK : S_IDLE;
                    end
                    S_BIT_MARK: if (rise)
                        state <= in_window(len_cnt, 1) ? S_BIT_SPACE : S_IDLE;
                    S_BIT_SPACE: if (fall) begin
                        if (!space_zero && !space_one) begin
                            state <= S_IDLE;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                            state <= (bit_cnt == 5'd31) ? S_STOP : S_BIT_MARK;
                        end
                    end
                    // rising edge at the end of the stop mark closes the frame
                    S_STOP: if (rise) begin
                        frame_done <= in_window(len_cnt, 1);
                        state <= S_IDLE;
                    end
                    default: state <= S_IDLE;
                endcase
            end
        end
    end

    // lsb first, so the first bit ends up in bit 0
    always_ff @(posedge clk_50) begin
        if (state == S_BIT_SPACE && fall && (space_zero || space_one))
            shift_reg <= {space_one, shift_reg[31:1]};
    end

    always_ff @(posedge clk_50) begin
        if (!rst_n)
            cmd_valid <= 1'b0;
        else
            cmd_valid <= frame_done && (shift_reg[23:16] == ~shift_reg[31:24]);
    end

    always_ff @(posedge clk_50) begin
        if (frame_done)
            cmd <= shift_reg[23:16];
    end

    assert property (@(posedge clk_50) disable iff (!rst_n) cmd_valid |=> !cmd_valid)
        else $error("cmd_valid high on two consecutive cycles");

endmodule

/* logic/motor_driver.sv */
`timescale 1ns/1ps
`include "rover_defines.svh"

module motor_driver #(
    parameter int pwm_period = `PWM_PERIOD_CYCLES
) (
    input  logic                    clk_50,
    input  logic                    rst_n,
    input  rover_pkg::drive_state_e drive,
    output rover_pkg::motor_cmd_t   motor
);

    localparam int CNT_W = (pwm_period > 1) ? $clog2(pwm_period) : 1;
    // enable while the counter is below these
    localparam logic [CNT_W-1:0] DUTY_SLOW   = CNT_W'(pwm_period / 4);
    localparam logic [CNT_W-1:0] DUTY_MEDIUM = CNT_W'(pwm_period / 2);
    localparam logic [CNT_W-1:0] DUTY_FAST   = CNT_W'((pwm_period * 3) / 4);

    logic [CNT_W-1:0]      pwm_cnt;
    rover_pkg::motor_cmd_t motor_next;

    always_ff @(posedge clk_50) begin
        if (!rst_n)
            pwm_cnt <= '0;
        else if (pwm_cnt == CNT_W'(pwm_period - 1))
            pwm_cnt <= '0;
        else
            pwm_cnt <= pwm_cnt + 1'b1;
    end

    always_comb begin
        motor_next = '0;
        case (drive)
            rover_pkg::SLOW: begin
                motor_next.left_en  = pwm_cnt < DUTY_SLOW;
                motor_next.right_en = pwm_cnt < DUTY_SLOW;
            end
            rover_pkg::MEDIUM: begin
                motor_next.left_en  = pwm_cnt < DUTY_MEDIUM;
                motor_next.right_en = pwm_cnt < DUTY_MEDIUM;
            end
            rover_pkg::FAST: begin
                motor_next.left_en  = pwm_cnt < DUTY_FAST;
                motor_next.right_en = pwm_cnt < DUTY_FAST;
            end
            // turns spin in place at full enable
            rover_pkg::LEFT: motor_next = '{left_en: 1'b1, left_rev: 1'b1,
                                            right_en: 1'b1, right_rev: 1'b0};
            rover_pkg::RIGHT: motor_next = '{left_en: 1'b1, left_rev: 1'b0,
                                             right_en: 1'b1, right_rev: 1'b1};
            default: motor_next = '0;
        endcase
    end

    always_ff @(posedge clk_50) begin
        if (!rst_n)
            motor <= '0;
        else
            motor <= motor_next;
    end

    assert property (@(posedge clk_50) disable iff (!rst_n)
        (drive == rover_pkg::STOP) |=> (!motor.left_en && !motor.right_en))
        else $error("wheel enabled after a STOP drive");

endmodule

/* logic/rover_defines.svh */
`ifndef ROVER_DEFINES_SVH
`define ROVER_DEFINES_SVH

// one IR time unit is 560 us at 50 MHz
`define IR_UNIT_CYCLES 28000

// frame phase lengths in IR units
`define IR_LEAD_MARK_UNITS 16
`define IR_LEAD_SPACE_UNITS 8
`define IR_ZERO_SPACE_UNITS 1
`define IR_ONE_SPACE_UNITS 3

// accepted window is nominal * LOW/DEN up to nominal * HIGH/DEN (+-25 %)
`define IR_TOL_LOW_NUM 3
`define IR_TOL_HIGH_NUM 5
`define IR_TOL_DEN 4

`define PWM_PERIOD_CYCLES 2500

// remote button codes
`define BTN_CAM 8'h0f
`define BTN_IR 8'h13
`define BTN_IDLE 8'h10
`define BTN_LEFT 8'h11
`define BTN_RIGHT 8'h12
`define BTN_SLOW 8'h14
`define BTN_MEDIUM 8'h15
`define BTN_FAST 8'h16
`define BTN_STOP 8'h17

`endif

/* logic/rover_mode_fsm.sv */
`timescale 1ns/1ps
`include "rover_defines.svh"

module rover_mode_fsm (
    input  logic                    clk_50,
    input  logic                    rst_n,
    input  rover_pkg::ir_cmd_t      cmd,
    input  logic                    cmd_valid,
    input  logic                    orange_detected,
    input  rover_pkg::cam_dir_t     cam_direction,
    input  rover_pkg::speed_t       speed,
    output rover_pkg::rover_mode_e  mode,
    output rover_pkg::cam_state_e   cam_state,
    output rover_pkg::drive_state_e drive,
    output logic                    mode_change
);

    rover_pkg::rover_mode_e  mode_next;
    rover_pkg::cam_state_e   cam_next;
    rover_pkg::drive_state_e drive_next;
    rover_pkg::drive_state_e manual_drive;
    rover_pkg::drive_state_e manual_next;

    always_comb begin
        mode_next = mode;
        if (cmd_valid) begin
            case (mode)
                rover_pkg::IDLE: begin
                    if (cmd == `BTN_CAM) mode_next = rover_pkg::CAM;
                    else if (cmd == `BTN_IR) mode_next = rover_pkg::IR;
                end
                rover_pkg::CAM: begin
                    if (cmd == `BTN_IR) mode_next = rover_pkg::IR;
                    else if (cmd == `BTN_IDLE) mode_next = rover_pkg::IDLE;
                end
                rover_pkg::IR: begin
                    if (cmd == `BTN_CAM) mode_next = rover_pkg::CAM;
                    else if (cmd == `BTN_IDLE) mode_next = rover_pkg::IDLE;
                end
                default: mode_next = rover_pkg::IDLE;
            endcase
        end
    end

    // search and follow both track orange_detected, pause restarts in search
    always_comb begin
        if (mode_next != rover_pkg::CAM)
            cam_next = rover_pkg::PAUSE;
        else if (cam_state == rover_pkg::PAUSE)
            cam_next = rover_pkg::SEARCH;
        else
            cam_next = orange_detected ? rover_pkg::FOLLOW : rover_pkg::SEARCH;
    end

    // held manual drive, kept at stop outside IR so entry starts stopped
    always_comb begin
        manual_next = manual_drive;
        if (mode != rover_pkg::IR || mode_next != rover_pkg::IR) begin
            manual_next = rover_pkg::STOP;
        end else if (cmd_valid) begin
            case (cmd)
                `BTN_LEFT:   manual_next = rover_pkg::LEFT;
                `BTN_RIGHT:  manual_next = rover_pkg::RIGHT;
                `BTN_SLOW:   manual_next = rover_pkg::SLOW;
                `BTN_MEDIUM: manual_next = rover_pkg::MEDIUM;
                `BTN_FAST:   manual_next = rover_pkg::FAST;
                `BTN_STOP:   manual_next = rover_pkg::STOP;
                default:     manual_next = manual_drive;
            endcase
        end
    end

    always_comb begin
        drive_next = rover_pkg::STOP;
        if (mode_next == rover_pkg::CAM) begin
            if (cam_next == rover_pkg::SEARCH) begin
                // spin right while looking for the target
                drive_next = rover_pkg::RIGHT;
            end else if (cam_next == rover_pkg::FOLLOW) begin
                case (cam_direction)
                    3'b010: drive_next = rover_pkg::RIGHT;
                    3'b001: drive_next = rover_pkg::LEFT;
                    3'b011: begin
                        case (speed)
                            2'd0:    drive_next = rover_pkg::SLOW;
                            2'd1:    drive_next = rover_pkg::MEDIUM;
                            2'd2:    drive_next = rover_pkg::FAST;
                            default: drive_next = rover_pkg::STOP;
                        endcase
                    end
                    default: drive_next = rover_pkg::STOP;
                endcase
            end
        end else if (mode_next == rover_pkg::IR) begin
            drive_next = manual_next;
        end
    end

    always_ff @(posedge clk_50) begin
        if (!rst_n) begin
            mode         <= rover_pkg::IDLE;
            cam_state    <= rover_pkg::PAUSE;
            drive        <= rover_pkg::STOP;
            manual_drive <= rover_pkg::STOP;
            mode_change  <= 1'b0;
        end else begin
            mode         <= mode_next;
            cam_state    <= cam_next;
            drive        <= drive_next;
            manual_drive <= manual_next;
            mode_change  <= (mode_next != mode) || (cam_next != cam_state);
        end
    end

    assert property (@(posedge clk_50) disable iff (!rst_n)
        (mode != rover_pkg::CAM) |-> (cam_state == rover_pkg::PAUSE))
        else $error("camera sub-state active outside CAM mode");

    assert property (@(posedge clk_50) disable iff (!rst_n)
        (mode == rover_pkg::IDLE) |-> (drive == rover_pkg::STOP))
        else $error("drive not stopped in IDLE mode");

endmodule

/* logic/rover_pkg.sv */
package rover_pkg;

    typedef logic [7:0] ir_cmd_t;
    // 001 target left, 010 target right, 011 centred
    typedef logic [2:0] cam_dir_t;
    typedef logic [1:0] speed_t;
    // active high, bit 0 drives segment a
    typedef logic [6:0] seg_t;

    typedef enum logic [1:0] {
        IDLE = 2'b00,
        CAM  = 2'b01,
        IR   = 2'b10
    } rover_mode_e;

    typedef enum logic [1:0] {
        SEARCH = 2'b00,
        FOLLOW = 2'b01,
        PAUSE  = 2'b11
    } cam_state_e;

    // the encoding doubles as the number shown on the display
    typedef enum logic [2:0] {
        STOP   = 3'b000,
        LEFT   = 3'b001,
        RIGHT  = 3'b010,
        SLOW   = 3'b011,
        MEDIUM = 3'b100,
        FAST   = 3'b101
    } drive_state_e;

    typedef struct packed {
        logic left_en;
        logic left_rev;
        logic right_en;
        logic right_rev;
    } motor_cmd_t;

    typedef struct packed {
        seg_t hex7;
        seg_t hex6;
        seg_t hex5;
        seg_t hex4;
        seg_t hex3;
        seg_t hex2;
        seg_t hex1;
        seg_t hex0;
    } hex_digits_t;

    localparam seg_t SEG_BLANK = 7'h00;
    localparam seg_t SEG_I     = 7'h30;
    localparam seg_t SEG_C     = 7'h39;
    localparam seg_t SEG_R     = 7'h50;
    localparam seg_t SEG_S     = 7'h6d;
    localparam seg_t SEG_F     = 7'h71;
    localparam seg_t SEG_P     = 7'h73;
    localparam seg_t SEG_L     = 7'h38;
    localparam seg_t SEG_DASH  = 7'h40;

    localparam seg_t SEG_DIGIT [0:5] = '{7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d};

endpackage

/* logic/rover_top.sv */
`timescale 1ns/1ps
`include "rover_defines.svh"

module rover_top #(
    parameter int unit_cycles = `IR_UNIT_CYCLES,
    parameter int pwm_period  = `PWM_PERIOD_CYCLES
) (
    input  logic                    clk_50,
    input  logic                    rst_n,
    input  logic                    ir_line,
    input  logic                    orange_detected,
    input  rover_pkg::cam_dir_t     cam_direction,
    input  rover_pkg::speed_t       speed,
    output rover_pkg::rover_mode_e  mode,
    output rover_pkg::cam_state_e   cam_state,
    output rover_pkg::drive_state_e drive,
    output logic                    mode_change,
    output rover_pkg::motor_cmd_t   motor,
    output rover_pkg::hex_digits_t  hex
);

    rover_pkg::ir_cmd_t cmd;
    logic               cmd_valid;

    ir_frame_decoder #(
        .unit_cycles(unit_cycles)
    ) u_decoder (
        .clk_50   (clk_50),
        .rst_n    (rst_n),
        .ir_line  (ir_line),
        .cmd      (cmd),
        .cmd_valid(cmd_valid)
    );

    rover_mode_fsm u_fsm (
        .clk_50         (clk_50),
        .rst_n          (rst_n),
        .cmd            (cmd),
        .cmd_valid      (cmd_valid),
        .orange_detected(orange_detected),
        .cam_direction  (cam_direction),
        .speed          (speed),
        .mode           (mode),
        .cam_state      (cam_state),
        .drive          (drive),
        .mode_change    (mode_change)
    );

    motor_driver #(
        .pwm_period(pwm_period)
    ) u_motor (
        .clk_50(clk_50),
        .rst_n (rst_n),
        .drive (drive),
        .motor (motor)
    );

    status_display u_display (
        .clk_50   (clk_50),
        .rst_n    (rst_n),
        .mode     (mode),
        .cam_state(cam_state),
        .drive    (drive),
        .hex      (hex)
    );

endmodule

/* logic/status_display.sv */
`timescale 1ns/1ps

module status_display (
    input  logic                    clk_50,
    input  logic                    rst_n,
    input  rover_pkg::rover_mode_e  mode,
    input  rover_pkg::cam_state_e   cam_state,
    input  rover_pkg::drive_state_e drive,
    output rover_pkg::hex_digits_t  hex
);

    rover_pkg::hex_digits_t hex_next;

    always_comb begin
        hex_next = {8{rover_pkg::SEG_BLANK}};

        case (mode)
            rover_pkg::CAM: hex_next.hex7 = rover_pkg::SEG_C;
            rover_pkg::IR:  hex_next.hex7 = rover_pkg::SEG_R;
            default:        hex_next.hex7 = rover_pkg::SEG_DASH;
        endcase

        case (cam_state)
            rover_pkg::SEARCH: hex_next.hex6 = rover_pkg::SEG_S;
            rover_pkg::FOLLOW: hex_next.hex6 = rover_pkg::SEG_F;
            rover_pkg::PAUSE:  hex_next.hex6 = rover_pkg::SEG_P;
            default:           hex_next.hex6 = rover_pkg::SEG_BLANK;
        endcase

        // drive code shown as its number, 0 for stop up to 5 for fast
        if (drive <= rover_pkg::FAST)
            hex_next.hex5 = rover_pkg::SEG_DIGIT[drive];
    end

    always_ff @(posedge clk_50) begin
        if (!rst_n)
            hex <= {rover_pkg::SEG_DASH, {7{rover_pkg::SEG_BLANK}}};
        else
            hex <= hex_next;
    end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# builds the rover testbench with Verilator and runs it

set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
    -f filelist.f \
    --top-module rover_tb \
    -o vrover_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/vrover_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "SIMULATION FAILED" "$LOG"; then
    exit 1
fi

exit 0

/* tb/rover_tb.sv */
`timescale 1ns/1ps
`include "rover_defines.svh"

module rover_tb;

    localparam int UNIT = 8;
    localparam int PWM_P = 8;

    logic                    clk_50;
    logic                    rst_n;
    logic                    ir_line;
    logic                    orange_detected;
    rover_pkg::cam_dir_t     cam_direction;
    rover_pkg::speed_t       speed;
    rover_pkg::rover_mode_e  mode;
    rover_pkg::cam_state_e   cam_state;
    rover_pkg::drive_state_e drive;
    logic                    mode_change;
    rover_pkg::motor_cmd_t   motor;
    rover_pkg::hex_digits_t  hex;

    // reference model of the controller, one register stage like the DUT
    rover_pkg::rover_mode_e  model_mode;
    rover_pkg::cam_state_e   model_cam;
    rover_pkg::drive_state_e model_drive;
    rover_pkg::drive_state_e model_manual;
    logic                    model_mc;
    logic [2:0]              model_pwm;
    rover_pkg::motor_cmd_t   exp_motor;
    rover_pkg::hex_digits_t  exp_hex;

    int       errors = 0;
    int       passed = 0;
    int       failed = 0;
    int       err_mark = 0;
    integer   seed = 32'ha152;
    string    test_name = "reset";
    logic     pending_good = 1'b0;
    logic [7:0] pending_cmd = 8'h00;

    tb_clock clock_gen (
        .clk_50(clk_50),
        .rst_n (rst_n)
    );

    rover_top #(
        .unit_cycles(UNIT),
        .pwm_period (PWM_P)
    ) dut (
        .clk_50         (clk_50),
        .rst_n          (rst_n),
        .ir_line        (ir_line),
        .orange_detected(orange_detected),
        .cam_direction  (cam_direction),
        .speed          (speed),
        .mode           (mode),
        .cam_state      (cam_state),
        .drive          (drive),
        .mode_change    (mode_change),
        .motor          (motor),
        .hex            (hex)
    );

    task automatic note_mismatch(input string what, input logic [63:0] exp_v,
                                 input logic [63:0] act_v);
        errors++;
        $display("Error %s: %s expected %0h actual %0h", test_name, what, exp_v, act_v);
    endtask

    task automatic log_failure(input string what);
        errors++;
        $display("%s: %s", test_name, what);
    endtask

    function automatic rover_pkg::seg_t mode_digit(input rover_pkg::rover_mode_e m);
        case (m)
            rover_pkg::CAM: return rover_pkg::SEG_C;
            rover_pkg::IR:  return rover_pkg::SEG_R;
            default:        return rover_pkg::SEG_DASH;
        endcase
    endfunction

    function automatic rover_pkg::seg_t cam_digit(input rover_pkg::cam_state_e c);
        case (c)
            rover_pkg::SEARCH: return rover_pkg::SEG_S;
            rover_pkg::FOLLOW: return rover_pkg::SEG_F;
            default:           return rover_pkg::SEG_P;
        endcase
    endfunction

    always @(posedge clk_50) begin : model_step
        rover_pkg::rover_mode_e  m_n;
        rover_pkg::cam_state_e   c_n;
        rover_pkg::drive_state_e d_n;
        rover_pkg::drive_state_e man_n;
        logic                    en;
        if (!rst_n) begin
            model_mode   <= rover_pkg::IDLE;
            model_cam    <= rover_pkg::PAUSE;
            model_drive  <= rover_pkg::STOP;
            model_manual <= rover_pkg::STOP;
            model_mc     <= 1'b0;
            model_pwm    <= '0;
            exp_motor    <= '0;
            exp_hex      <= {rover_pkg::SEG_DASH, {7{rover_pkg::SEG_BLANK}}};
        end else begin
            m_n = model_mode;
            if (dut.cmd_valid) begin
                if (pending_cmd == `BTN_CAM && model_mode != rover_pkg::CAM)
                    m_n = rover_pkg::CAM;
                else if (pending_cmd == `BTN_IR && model_mode != rover_pkg::IR)
                    m_n = rover_pkg::IR;
                else if (pending_cmd == `BTN_IDLE && model_mode != rover_pkg::IDLE)
                    m_n = rover_pkg::IDLE;
            end
            if (m_n != rover_pkg::CAM)
                c_n = rover_pkg::PAUSE;
            else if (model_cam == rover_pkg::PAUSE)
                c_n = rover_pkg::SEARCH;
            else
                c_n = orange_detected ? rover_pkg::FOLLOW : rover_pkg::SEARCH;
            man_n = model_manual;
            if (!(model_mode == rover_pkg::IR && m_n == rover_pkg::IR))
                man_n = rover_pkg::STOP;
            else if (dut.cmd_valid && pending_cmd == `BTN_LEFT)
                man_n = rover_pkg::LEFT;
            else if (dut.cmd_valid && pending_cmd == `BTN_RIGHT)
                man_n = rover_pkg::RIGHT;
            else if (dut.cmd_valid && pending_cmd == `BTN_SLOW)
                man_n = rover_pkg::SLOW;
            else if (dut.cmd_valid && pending_cmd == `BTN_MEDIUM)
                man_n = rover_pkg::MEDIUM;
            else if (dut.cmd_valid && pending_cmd == `BTN_FAST)
                man_n = rover_pkg::FAST;
            else if (dut.cmd_valid && pending_cmd == `BTN_STOP)
                man_n = rover_pkg::STOP;
            d_n = rover_pkg::STOP;
            if (m_n == rover_pkg::IR)
                d_n = man_n;
            else if (c_n == rover_pkg::SEARCH)
                d_n = rover_pkg::RIGHT;
            else if (c_n == rover_pkg::FOLLOW && cam_direction == 3'b010)
                d_n = rover_pkg::RIGHT;
            else if (c_n == rover_pkg::FOLLOW && cam_direction == 3'b001)
                d_n = rover_pkg::LEFT;
            else if (c_n == rover_pkg::FOLLOW && cam_direction == 3'b011 && speed == 2'd0)
                d_n = rover_pkg::SLOW;
            else if (c_n == rover_pkg::FOLLOW && cam_direction == 3'b011 && speed == 2'd1)
                d_n = rover_pkg::MEDIUM;
            else if (c_n == rover_pkg::FOLLOW && cam_direction == 3'b011 && speed == 2'd2)
                d_n = rover_pkg::FAST;
            // duty is a quarter, half or three quarters of the period
            case (model_drive)
                rover_pkg::SLOW:   en = int'(model_pwm) < PWM_P / 4;
                rover_pkg::MEDIUM: en = int'(model_pwm) < PWM_P / 2;
                rover_pkg::FAST:   en = int'(model_pwm) < (3 * PWM_P) / 4;
                default:           en = 1'b0;
            endcase
            if (model_drive == rover_pkg::LEFT)
                exp_motor <= '{left_en: 1'b1, left_rev: 1'b1, right_en: 1'b1, right_rev: 1'b0};
            else if (model_drive == rover_pkg::RIGHT)
                exp_motor <= '{left_en: 1'b1, left_rev: 1'b0, right_en: 1'b1, right_rev: 1'b1};
            else
                exp_motor <= '{left_en: en, left_rev: 1'b0, right_en: en, right_rev: 1'b0};
            exp_hex <= {mode_digit(model_mode), cam_digit(model_cam),
                        rover_pkg::SEG_DIGIT[int'(model_drive)], {5{rover_pkg::SEG_BLANK}}};
            model_pwm    <= (int'(model_pwm) == PWM_P - 1) ? 3'd0 : model_pwm + 3'd1;
            model_mc     <= (m_n != model_mode) || (c_n != model_cam);
            model_mode   <= m_n;
            model_cam    <= c_n;
            model_drive  <= d_n;
            model_manual <= man_n;
        end
    end

    assert property (@(posedge clk_50) disable iff (!rst_n) mode == model_mode)
        else note_mismatch("mode", model_mode, $sampled(mode));
    assert property (@(posedge clk_50) disable iff (!rst_n) cam_state == model_cam)
        else note_mismatch("cam_state", model_cam, $sampled(cam_state));
    assert property (@(posedge clk_50) disable iff (!rst_n) drive == model_drive)
        else note_mismatch("drive", model_drive, $sampled(drive));
    assert property (@(posedge clk_50) disable iff (!rst_n) mode_change == model_mc)
        else note_mismatch("mode_change", model_mc, $sampled(mode_change));
    assert property (@(posedge clk_50) disable iff (!rst_n) motor == exp_motor)
        else note_mismatch("motor", exp_motor, $sampled(motor));
    assert property (@(posedge clk_50) disable iff (!rst_n) hex == exp_hex)
        else note_mismatch("hex", exp_hex, $sampled(hex));
    assert property (@(posedge clk_50) disable iff (!rst_n) dut.cmd_valid |-> pending_good)
        else log_failure("command strobe without a good frame");
    assert property (@(posedge clk_50) disable iff (!rst_n)
        (dut.cmd_valid && pending_good) |-> dut.cmd == pending_cmd)
        else note_mismatch("cmd", pending_cmd, $sampled(dut.cmd));

    task automatic hold_line(input logic level, input int units);
        @(negedge clk_50);
        ir_line = level;
        repeat (units * UNIT - 1) @(negedge clk_50);
    endtask

    task automatic send_frame(input logic [7:0] code, input logic [7:0] addr,
                              input bit bad_inv, input bit short_lead);
        logic [31:0] word;
        word = {bad_inv ? code : ~code, code, ~addr, addr};
        hold_line(1'b0, short_lead ? 8 : `IR_LEAD_MARK_UNITS);
        hold_line(1'b1, `IR_LEAD_SPACE_UNITS);
        for (int i = 0; i < 32; i++) begin
            hold_line(1'b0, 1);
            hold_line(1'b1, word[i] ? `IR_ONE_SPACE_UNITS : `IR_ZERO_SPACE_UNITS);
        end
        hold_line(1'b0, 1);
        @(negedge clk_50);
        ir_line = 1'b1;
    endtask

    // a good frame must produce its strobe within a few cycles
    task automatic issue_command(input logic [7:0] code, input bit bad_inv, input bit short_lead);
        bit seen;
        seen = 1'b0;
        pending_cmd = code;
        pending_good = !bad_inv && !short_lead;
        send_frame(code, 8'($random(seed)), bad_inv, short_lead);
        for (int t = 0; t < 20 && !seen; t++) begin
            @(negedge clk_50);
            seen = dut.cmd_valid;
        end
        if (pending_good && !seen)
            log_failure("no command strobe after a good frame");
        // strobe is sampled on the next rising edge
        @(negedge clk_50);
        pending_good = 1'b0;
        // idle gap longer than any legal phase
        repeat (24 * UNIT) @(negedge clk_50);
    endtask

    task automatic finish_test();
        if (errors == err_mark) begin
            passed++;
            $display("test %s: ok", test_name);
        end else begin
            failed++;
            $display("test %s: failed with %0d errors", test_name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    task automatic count_enables(input int expected);
        int left_n;
        int right_n;
        left_n = 0;
        right_n = 0;
        repeat (4) @(negedge clk_50);
        for (int i = 0; i < PWM_P; i++) begin
            @(negedge clk_50);
            left_n += motor.left_en;
            right_n += motor.right_en;
        end
        assert (left_n == expected) else note_mismatch("left enable count", expected, left_n);
        assert (right_n == expected) else note_mismatch("right enable count", expected, right_n);
    endtask

    initial begin
        repeat (200000) @(posedge clk_50);
        $display("timeout: the simulation did not finish in time");
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        ir_line = 1'b1;
        orange_detected = 1'b0;
        cam_direction = 3'b000;
        speed = 2'd0;
        for (int t = 0; t < 50 && rst_n !== 1'b1; t++)
            @(negedge clk_50);
        if (rst_n !== 1'b1)
            log_failure("reset was never released");
        repeat (3) @(negedge clk_50);
        assert (motor == '0) else note_mismatch("motor", 0, motor);
        assert (hex.hex7 == rover_pkg::SEG_DASH) else note_mismatch("hex7", 8'h40, hex.hex7);
        finish_test();

        test_name = "mode switching";
        issue_command(`BTN_CAM, 0, 0);
        issue_command(8'h42, 0, 0);
        issue_command(`BTN_IR, 0, 0);
        issue_command(`BTN_CAM, 0, 0);
        issue_command(`BTN_IDLE, 0, 0);
        issue_command(`BTN_IR, 0, 0);
        issue_command(`BTN_IDLE, 0, 0);
        issue_command(`BTN_IDLE, 0, 0);
        finish_test();

        test_name = "corrupted frames";
        issue_command(`BTN_CAM, 1, 0);
        issue_command(`BTN_CAM, 0, 0);
        issue_command(`BTN_IR, 0, 1);
        issue_command(`BTN_IR, 0, 0);
        finish_test();

        test_name = "camera tracking";
        issue_command(`BTN_CAM, 0, 0);
        for (int i = 0; i < 60; i++) begin
            @(negedge clk_50);
            orange_detected = 1'($random(seed));
            cam_direction = 3'($random(seed));
            speed = 2'($random(seed));
        end
        orange_detected = 1'b1;
        for (int d = 0; d < 4; d++) begin
            for (int s = 0; s < 4; s++) begin
                @(negedge clk_50);
                cam_direction = 3'(d);
                speed = 2'(s);
                repeat (2) @(negedge clk_50);
            end
        end
        finish_test();

        test_name = "manual drive";
        issue_command(`BTN_IR, 0, 0);
        issue_command(`BTN_LEFT, 0, 0);
        issue_command(`BTN_FAST, 0, 0);
        issue_command(`BTN_STOP, 0, 0);
        issue_command(`BTN_RIGHT, 0, 0);
        issue_command(`BTN_IDLE, 0, 0);
        issue_command(`BTN_IR, 0, 0);
        assert (drive == rover_pkg::STOP) else note_mismatch("drive", 0, drive);
        finish_test();

        test_name = "pwm";
        issue_command(`BTN_SLOW, 0, 0);
        count_enables(2);
        issue_command(`BTN_MEDIUM, 0, 0);
        count_enables(4);
        issue_command(`BTN_FAST, 0, 0);
        count_enables(6);
        issue_command(`BTN_LEFT, 0, 0);
        assert (motor.left_rev && !motor.right_rev) else log_failure("wrong LEFT direction");
        issue_command(`BTN_RIGHT, 0, 0);
        assert (!motor.left_rev && motor.right_rev) else log_failure("wrong RIGHT direction");
        finish_test();

        $display("tests passed %0d, tests failed %0d, errors %0d", passed, failed, errors);
        if (errors == 0 && failed == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

/* tb/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
    parameter int period_ns = 100,
    parameter int reset_cycles = 4
) (
    output logic clk_50,
    output logic rst_n
);

    initial begin
        clk_50 = 1'b0;
        forever #(period_ns / 2) clk_50 = ~clk_50;
    end

    // reset released on a falling edge, clear of the sampling edge
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk_50);
        @(negedge clk_50);
        rst_n = 1'b1;
    end

endmodule
